// File: axi_bridge_cfg.svh
`ifndef AXI_BRIDGE_CFG_SVH
`define AXI_BRIDGE_CFG_SVH

// Bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W 4
`define AXI_LEN_W  8

// FIFO depths as powers of two
`define ADDR_FIFO_DEPTH_LOG2 2
`define DATA_FIFO_DEPTH_LOG2 4

// RAM word index width, 256 words
`define RAM_ADDR_W 8

`endif

// File: axi_bridge_pkg.sv
`default_nettype none

`include "axi_bridge_cfg.svh"

package axi_bridge_pkg;

    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;   // Beats minus one
    } addr_req_t;

    typedef struct packed {
        logic [`AXI_STRB_W-1:0] strb;
        logic [`AXI_DATA_W-1:0] data;
        logic                   last;
    } wr_beat_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic                   last;
    } rd_beat_t;

    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_WRITE,
        RAM_READ
    } ram_state_e;

endpackage

`default_nettype wire

// File: axi_slave_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_slave_if (
    input wire SLAVE_CLK
);
    import axi_bridge_pkg::*;

    addr_req_t wr_addr;
    logic      wr_addr_valid;
    logic      wr_addr_ready;

    wr_beat_t  wr_beat;
    logic      wr_data_valid;
    logic      wr_data_ready;

    addr_req_t rd_addr;
    logic      rd_addr_valid;
    logic      rd_addr_ready;

    rd_beat_t  rd_beat;
    logic      rd_data_valid;
    logic      rd_data_ready;

    modport bridge (
        input  SLAVE_CLK,
        output wr_addr, wr_addr_valid, input  wr_addr_ready,
        output wr_beat, wr_data_valid, input  wr_data_ready,
        output rd_addr, rd_addr_valid, input  rd_addr_ready,
        input  rd_beat, rd_data_valid, output rd_data_ready
    );

    modport ram (
        input  SLAVE_CLK,
        input  wr_addr, wr_addr_valid, output wr_addr_ready,
        input  wr_beat, wr_data_valid, output wr_data_ready,
        input  rd_addr, rd_addr_valid, output rd_addr_ready,
        output rd_beat, rd_data_valid, input  rd_data_ready
    );

endinterface

`default_nettype wire

// File: async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 2
) (
    input  wire              wr_clk,
    input  wire              wr_rst,
    input  wire              wr_en,
    input  wire  [WIDTH-1:0] wr_data,
    output logic             wr_full,

    input  wire              rd_clk,
    input  wire              rd_rst,
    input  wire              rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_empty
);
    localparam int DEPTH = 1 << DEPTH_LOG2;
    localparam int PTR_W = DEPTH_LOG2 + 1;  // One extra bit tells full from empty

    logic [WIDTH-1:0] mem [DEPTH];

    logic [PTR_W-1:0] wr_bin;
    logic [PTR_W-1:0] wr_bin_next;
    logic [PTR_W-1:0] wr_gray;
    logic [PTR_W-1:0] rd_gray_s1;
    logic [PTR_W-1:0] rd_gray_s2;
    logic             wr_push;

    logic [PTR_W-1:0] rd_bin;
    logic [PTR_W-1:0] rd_bin_next;
    logic [PTR_W-1:0] rd_gray;
    logic [PTR_W-1:0] wr_gray_s1;
    logic [PTR_W-1:0] wr_gray_s2;
    logic             rd_pop;

    assign wr_push     = wr_en && !wr_full;
    assign wr_bin_next = wr_bin + PTR_W'(wr_push);

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_push) begin
            mem[wr_bin[DEPTH_LOG2-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    // Full when the read pointer is one lap behind, top two Gray bits inverted
    assign wr_full = (wr_gray == {~rd_gray_s2[PTR_W-1 -: 2], rd_gray_s2[PTR_W-3:0]});

    assign rd_pop      = rd_en && !rd_empty;
    assign rd_bin_next = rd_bin + PTR_W'(rd_pop);

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_pop) begin
            rd_data <= mem[rd_bin[DEPTH_LOG2-1:0]];
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    assign rd_empty = (rd_gray == wr_gray_s2);

endmodule

`default_nettype wire

// File: slave_axi_async.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module slave_axi_async (
    input  wire                       BUS_CLK,
    input  wire                       SLAVE_CLK,
    input  wire                       BUS_RST,

    input  wire axi_bridge_pkg::addr_req_t bus_wr_addr,
    input  wire                       bus_wr_addr_valid,
    output logic                      bus_wr_addr_ready,

    input  wire axi_bridge_pkg::wr_beat_t  bus_wr_data,
    input  wire                       bus_wr_data_valid,
    output logic                      bus_wr_data_ready,

    input  wire axi_bridge_pkg::addr_req_t bus_rd_addr,
    input  wire                       bus_rd_addr_valid,
    output logic                      bus_rd_addr_ready,

    output axi_bridge_pkg::rd_beat_t  bus_rd_data,
    output logic                      bus_rd_data_valid,
    input  wire                       bus_rd_data_ready,

    axi_slave_if.bridge               slv
);
    import axi_bridge_pkg::*;

    // Channels crossing into SLAVE_CLK: 0 write address, 1 write data, 2 read address
    localparam int N_SLV = 3;

    logic [N_SLV-1:0] src_push;
    logic [N_SLV-1:0] src_full;
    logic [N_SLV-1:0] dst_empty;
    logic [N_SLV-1:0] dst_pop;
    logic [N_SLV-1:0] dst_xfer;
    logic [N_SLV-1:0] dst_hold;

    logic rd_push;
    logic rd_full;
    logic rd_empty;
    logic rd_pop;
    logic rd_xfer;
    logic rd_hold;

    assign bus_wr_addr_ready = !BUS_RST && !src_full[0];
    assign bus_wr_data_ready = !BUS_RST && !src_full[1];
    assign bus_rd_addr_ready = !BUS_RST && !src_full[2];

    assign src_push[0] = bus_wr_addr_valid && bus_wr_addr_ready;
    assign src_push[1] = bus_wr_data_valid && bus_wr_data_ready;
    assign src_push[2] = bus_rd_addr_valid && bus_rd_addr_ready;

    assign slv.wr_addr_valid = !dst_hold[0];
    assign slv.wr_data_valid = !dst_hold[1];
    assign slv.rd_addr_valid = !dst_hold[2];

    assign dst_xfer[0] = slv.wr_addr_valid && slv.wr_addr_ready;
    assign dst_xfer[1] = slv.wr_data_valid && slv.wr_data_ready;
    assign dst_xfer[2] = slv.rd_addr_valid && slv.rd_addr_ready;

    // Hold set means the FIFO output register carries nothing to present
    for (genvar i = 0; i < N_SLV; i++) begin : g_hold
        assign dst_pop[i] = !dst_empty[i] && (dst_hold[i] || dst_xfer[i]);

        always_ff @(posedge SLAVE_CLK) begin
            if (BUS_RST) begin
                dst_hold[i] <= 1'b1;
            end else if (dst_empty[i] && dst_xfer[i]) begin
                dst_hold[i] <= 1'b1;  // Last entry left, nothing behind it
            end else if (dst_pop[i]) begin
                dst_hold[i] <= 1'b0;
            end
        end
    end

    async_fifo #(
        .WIDTH      ($bits(addr_req_t)),
        .DEPTH_LOG2 (`ADDR_FIFO_DEPTH_LOG2)
    ) i_wr_addr_fifo (
        .wr_clk   (BUS_CLK),
        .wr_rst   (BUS_RST),
        .wr_en    (src_push[0]),
        .wr_data  (bus_wr_addr),
        .wr_full  (src_full[0]),
        .rd_clk   (SLAVE_CLK),
        .rd_rst   (BUS_RST),
        .rd_en    (dst_pop[0]),
        .rd_data  (slv.wr_addr),
        .rd_empty (dst_empty[0])
    );

    async_fifo #(
        .WIDTH      ($bits(wr_beat_t)),
        .DEPTH_LOG2 (`DATA_FIFO_DEPTH_LOG2)
    ) i_wr_data_fifo (
        .wr_clk   (BUS_CLK),
        .wr_rst   (BUS_RST),
        .wr_en    (src_push[1]),
        .wr_data  (bus_wr_data),
        .wr_full  (src_full[1]),
        .rd_clk   (SLAVE_CLK),
        .rd_rst   (BUS_RST),
        .rd_en    (dst_pop[1]),
        .rd_data  (slv.wr_beat),
        .rd_empty (dst_empty[1])
    );

    async_fifo #(
        .WIDTH      ($bits(addr_req_t)),
        .DEPTH_LOG2 (`ADDR_FIFO_DEPTH_LOG2)
    ) i_rd_addr_fifo (
        .wr_clk   (BUS_CLK),
        .wr_rst   (BUS_RST),
        .wr_en    (src_push[2]),
        .wr_data  (bus_rd_addr),
        .wr_full  (src_full[2]),
        .rd_clk   (SLAVE_CLK),
        .rd_rst   (BUS_RST),
        .rd_en    (dst_pop[2]),
        .rd_data  (slv.rd_addr),
        .rd_empty (dst_empty[2])
    );

    // Read data runs the other way, SLAVE_CLK into BUS_CLK
    assign slv.rd_data_ready = !BUS_RST && !rd_full;
    assign rd_push           = slv.rd_data_valid && slv.rd_data_ready;
    assign bus_rd_data_valid = !rd_hold;
    assign rd_xfer           = bus_rd_data_valid && bus_rd_data_ready;
    assign rd_pop            = !rd_empty && (rd_hold || rd_xfer);

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            rd_hold <= 1'b1;
        end else if (rd_empty && rd_xfer) begin
            rd_hold <= 1'b1;
        end else if (rd_pop) begin
            rd_hold <= 1'b0;
        end
    end

    async_fifo #(
        .WIDTH      ($bits(rd_beat_t)),
        .DEPTH_LOG2 (`DATA_FIFO_DEPTH_LOG2)
    ) i_rd_data_fifo (
        .wr_clk   (SLAVE_CLK),
        .wr_rst   (BUS_RST),
        .wr_en    (rd_push),
        .wr_data  (slv.rd_beat),
        .wr_full  (rd_full),
        .rd_clk   (BUS_CLK),
        .rd_rst   (BUS_RST),
        .rd_en    (rd_pop),
        .rd_data  (bus_rd_data),
        .rd_empty (rd_empty)
    );

endmodule

`default_nettype wire

// File: slave_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module slave_ram (
    input  wire      SLAVE_CLK,
    input  wire      BUS_RST,
    axi_slave_if.ram slv
);
    import axi_bridge_pkg::*;

    logic [`AXI_DATA_W-1:0] mem [1 << `RAM_ADDR_W];

    ram_state_e             state;
    logic [`RAM_ADDR_W-1:0] ptr;     // Word of the next beat
    logic [`AXI_LEN_W-1:0]  remain;  // Beats still to load after the one on the bus
    logic [`RAM_ADDR_W-1:0] rd_start;

    logic wr_addr_xfer;
    logic wr_xfer;
    logic rd_addr_xfer;
    logic rd_xfer;

    assign slv.wr_addr_ready = !BUS_RST && (state == RAM_IDLE);
    assign slv.rd_addr_ready = !BUS_RST && (state == RAM_IDLE) && !slv.wr_addr_valid;  // Write wins
    assign slv.wr_data_ready = !BUS_RST && (state == RAM_WRITE);

    assign wr_addr_xfer = slv.wr_addr_valid && slv.wr_addr_ready;
    assign wr_xfer      = slv.wr_data_valid && slv.wr_data_ready;
    assign rd_addr_xfer = slv.rd_addr_valid && slv.rd_addr_ready;
    assign rd_xfer      = slv.rd_data_valid && slv.rd_data_ready;

    assign rd_start = slv.rd_addr.addr[`RAM_ADDR_W+1:2];

    always_ff @(posedge SLAVE_CLK) begin
        if (wr_xfer) begin
            for (int b = 0; b < `AXI_STRB_W; b++) begin
                if (slv.wr_beat.strb[b]) begin
                    mem[ptr][8*b +: 8] <= slv.wr_beat.data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge SLAVE_CLK) begin
        if (BUS_RST) begin
            state             <= RAM_IDLE;
            ptr               <= '0;
            remain            <= '0;
            slv.rd_data_valid <= 1'b0;
        end else begin
            case (state)
                RAM_IDLE: begin
                    if (wr_addr_xfer) begin
                        ptr   <= slv.wr_addr.addr[`RAM_ADDR_W+1:2];
                        state <= RAM_WRITE;
                    end else if (rd_addr_xfer) begin
                        ptr               <= rd_start + 1'b1;  // First beat is loaded now
                        remain            <= slv.rd_addr.len;
                        slv.rd_data_valid <= 1'b1;
                        state             <= RAM_READ;
                    end
                end
                RAM_WRITE: begin
                    if (wr_xfer) begin
                        ptr <= ptr + 1'b1;
                        if (slv.wr_beat.last) begin
                            state <= RAM_IDLE;
                        end
                    end
                end
                RAM_READ: begin
                    if (rd_xfer) begin
                        if (slv.rd_beat.last) begin
                            slv.rd_data_valid <= 1'b0;
                            state             <= RAM_IDLE;
                        end else begin
                            ptr    <= ptr + 1'b1;
                            remain <= remain - 1'b1;
                        end
                    end
                end
                default: begin
                    state <= RAM_IDLE;
                end
            endcase
        end
    end

    // A stalled beat keeps its payload until it transfers
    always_ff @(posedge SLAVE_CLK) begin
        if (rd_addr_xfer) begin
            slv.rd_beat.data <= mem[rd_start];
            slv.rd_beat.last <= (slv.rd_addr.len == '0);
        end else if (rd_xfer && !slv.rd_beat.last) begin
            slv.rd_beat.data <= mem[ptr];
            slv.rd_beat.last <= (remain == 1);
        end
    end

endmodule

`default_nettype wire

// File: axi_ram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module axi_ram_subsystem (
    input  wire                    BUS_CLK,
    input  wire                    SLAVE_CLK,
    input  wire                    BUS_RST,

    input  wire  [`AXI_ADDR_W-1:0] bus_wr_addr,
    input  wire  [`AXI_LEN_W-1:0]  bus_wr_len,
    input  wire                    bus_wr_addr_valid,
    output logic                   bus_wr_addr_ready,

    input  wire  [`AXI_DATA_W-1:0] bus_wr_data,
    input  wire  [`AXI_STRB_W-1:0] bus_wr_strb,
    input  wire                    bus_wr_data_last,
    input  wire                    bus_wr_data_valid,
    output logic                   bus_wr_data_ready,

    input  wire  [`AXI_ADDR_W-1:0] bus_rd_addr,
    input  wire  [`AXI_LEN_W-1:0]  bus_rd_len,
    input  wire                    bus_rd_addr_valid,
    output logic                   bus_rd_addr_ready,

    output logic [`AXI_DATA_W-1:0] bus_rd_data,
    output logic                   bus_rd_data_last,
    output logic                   bus_rd_data_valid,
    input  wire                    bus_rd_data_ready
);
    import axi_bridge_pkg::*;

    addr_req_t wr_req;
    addr_req_t rd_req;
    wr_beat_t  wr_beat;
    rd_beat_t  rd_beat;

    assign wr_req  = {bus_wr_addr, bus_wr_len};
    assign rd_req  = {bus_rd_addr, bus_rd_len};
    assign wr_beat = {bus_wr_strb, bus_wr_data, bus_wr_data_last};

    assign bus_rd_data      = rd_beat.data;
    assign bus_rd_data_last = rd_beat.last;

    axi_slave_if i_slv (
        .SLAVE_CLK (SLAVE_CLK)
    );

    slave_axi_async i_bridge (
        .BUS_CLK           (BUS_CLK),
        .SLAVE_CLK         (SLAVE_CLK),
        .BUS_RST           (BUS_RST),
        .bus_wr_addr       (wr_req),
        .bus_wr_addr_valid (bus_wr_addr_valid),
        .bus_wr_addr_ready (bus_wr_addr_ready),
        .bus_wr_data       (wr_beat),
        .bus_wr_data_valid (bus_wr_data_valid),
        .bus_wr_data_ready (bus_wr_data_ready),
        .bus_rd_addr       (rd_req),
        .bus_rd_addr_valid (bus_rd_addr_valid),
        .bus_rd_addr_ready (bus_rd_addr_ready),
        .bus_rd_data       (rd_beat),
        .bus_rd_data_valid (bus_rd_data_valid),
        .bus_rd_data_ready (bus_rd_data_ready),
        .slv               (i_slv)
    );

    slave_ram i_ram (
        .SLAVE_CLK (SLAVE_CLK),
        .BUS_RST   (BUS_RST),
        .slv       (i_slv)
    );

endmodule

`default_nettype wire

// File: tb_axi_ram_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_bridge_cfg.svh"

module tb_axi_ram_subsystem;
    import axi_bridge_pkg::*;

    typedef enum logic {
        ROW_WRITE,
        ROW_READ
    } row_kind_e;

    typedef struct packed {
        row_kind_e              kind;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
        logic [`AXI_STRB_W-1:0] strb;
        logic [31:0]            seed;  // Write data mask that also throttles a read when nonzero
    } stim_row_t;

    localparam int N_ROWS = 12;

    logic                   BUS_CLK;
    logic                   SLAVE_CLK;
    logic                   BUS_RST;
    logic [`AXI_ADDR_W-1:0] bus_wr_addr;
    logic [`AXI_LEN_W-1:0]  bus_wr_len;
    logic                   bus_wr_addr_valid;
    logic                   bus_wr_addr_ready;
    logic [`AXI_DATA_W-1:0] bus_wr_data;
    logic [`AXI_STRB_W-1:0] bus_wr_strb;
    logic                   bus_wr_data_last;
    logic                   bus_wr_data_valid;
    logic                   bus_wr_data_ready;
    logic [`AXI_ADDR_W-1:0] bus_rd_addr;
    logic [`AXI_LEN_W-1:0]  bus_rd_len;
    logic                   bus_rd_addr_valid;
    logic                   bus_rd_addr_ready;
    logic [`AXI_DATA_W-1:0] bus_rd_data;
    logic                   bus_rd_data_last;
    logic                   bus_rd_data_valid;
    logic                   bus_rd_data_ready;

    stim_row_t              rows [N_ROWS];
    logic [`AXI_DATA_W-1:0] ref_mem [1 << `RAM_ADDR_W];
    logic [31:0]            lcg_state;
    longint                 budget_ns;
    logic                   table_ready;

    axi_ram_subsystem i_axi_ram_subsystem (.*);

    initial begin
        SLAVE_CLK = 1'b0;
        forever #10 SLAVE_CLK = ~SLAVE_CLK;
    end

    initial begin
        BUS_CLK = 1'b0;
        forever #7 BUS_CLK = ~BUS_CLK;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0d ns: %s is %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_rd_beat(input rd_beat_t got, input logic [`RAM_ADDR_W-1:0] idx,
                                 input int beat, input int len);
        rd_beat_t exp;
        exp.data = ref_mem[idx];
        exp.last = (beat == len);
        if (got.data !== exp.data) begin
            fail_run($sformatf("mismatch at %0d ns: beat %0d of word %0d read %h, expected %h",
                               $time, beat, idx, got.data, exp.data));
        end
        if (got.last !== exp.last) begin
            fail_run($sformatf("mismatch at %0d ns: beat %0d of %0d has last %b, expected %b",
                               $time, beat, len + 1, got.last, exp.last));
        end
    endtask

    task automatic load_table();
        rows[0]  = '{ROW_WRITE, 32'h0000_0010, 8'd0,  4'hF,    32'h0000_0000};
        rows[1]  = '{ROW_READ,  32'h0000_0010, 8'd0,  4'hF,    32'h0000_0000};
        rows[2]  = '{ROW_WRITE, 32'h0000_0100, 8'd7,  4'hF,    32'h5A5A_0000};
        rows[3]  = '{ROW_READ,  32'h0000_0100, 8'd7,  4'hF,    32'h0000_0000};
        rows[4]  = '{ROW_WRITE, 32'h0000_03F0, 8'd7,  4'hF,    32'h0000_A5A5};  // Wraps past 255
        rows[5]  = '{ROW_READ,  32'h0000_03F0, 8'd7,  4'hF,    32'h0000_0001};
        rows[6]  = '{ROW_WRITE, 32'h0000_0104, 8'd3,  4'b0101, 32'hFFFF_0000};
        rows[7]  = '{ROW_READ,  32'h0000_0100, 8'd7,  4'hF,    32'h0000_0000};
        rows[8]  = '{ROW_WRITE, 32'h0000_0200, 8'd31, 4'hF,    32'h1234_5678};
        rows[9]  = '{ROW_READ,  32'h0000_0200, 8'd31, 4'hF,    32'h0000_0043};
        rows[10] = '{ROW_WRITE, 32'h0000_0010, 8'd0,  4'b0110, 32'h0000_0000};
        rows[11] = '{ROW_READ,  32'h0000_000C, 8'd1,  4'hF,    32'h0000_0000};
    endtask

    // Holds valid until the ready seen at a falling edge carries it over the next rising edge
    task automatic issue_addr(input row_kind_e kind, input logic [`AXI_ADDR_W-1:0] addr,
                              input logic [`AXI_LEN_W-1:0] len);
        @(negedge BUS_CLK);
        if (kind == ROW_WRITE) begin
            bus_wr_addr       = addr;
            bus_wr_len        = len;
            bus_wr_addr_valid = 1'b1;
            while (!bus_wr_addr_ready) @(negedge BUS_CLK);
            @(negedge BUS_CLK);
            bus_wr_addr_valid = 1'b0;
        end else begin
            bus_rd_addr       = addr;
            bus_rd_len        = len;
            bus_rd_addr_valid = 1'b1;
            while (!bus_rd_addr_ready) @(negedge BUS_CLK);
            @(negedge BUS_CLK);
            bus_rd_addr_valid = 1'b0;
        end
    endtask

    task automatic write_burst(input stim_row_t row);
        logic [`AXI_DATA_W-1:0] word;
        logic [`RAM_ADDR_W-1:0] idx;
        issue_addr(ROW_WRITE, row.addr, row.len);
        for (int i = 0; i <= row.len; i++) begin
            word              = next_random() ^ row.seed;
            idx               = row.addr[`RAM_ADDR_W+1:2] + `RAM_ADDR_W'(i);
            bus_wr_data       = word;
            bus_wr_strb       = row.strb;
            bus_wr_data_last  = (i == row.len);
            bus_wr_data_valid = 1'b1;
            while (!bus_wr_data_ready) @(negedge BUS_CLK);  // Full data FIFO stalls the beat
            for (int b = 0; b < `AXI_STRB_W; b++) begin
                if (row.strb[b]) begin
                    ref_mem[idx][8*b +: 8] = word[8*b +: 8];
                end
            end
            @(negedge BUS_CLK);
        end
        bus_wr_data_valid = 1'b0;
        bus_wr_data_last  = 1'b0;
        repeat (60) @(negedge BUS_CLK);  // Lets the burst drain into the RAM
    endtask

    task automatic read_burst(input stim_row_t row);
        rd_beat_t               got;
        logic [`RAM_ADDR_W-1:0] idx;
        logic [31:0]            rnd;
        int                     beat;
        beat = 0;
        check_flag(bus_rd_data_valid, 1'b0, "bus_rd_data_valid before a read");
        issue_addr(ROW_READ, row.addr, row.len);
        while (beat <= row.len) begin
            @(negedge BUS_CLK);
            if (row.seed != 0) begin
                rnd               = next_random();
                bus_rd_data_ready = (rnd[17:16] != 2'b00);  // Low about one cycle in four
            end else begin
                bus_rd_data_ready = 1'b1;
            end
            if (bus_rd_data_valid && bus_rd_data_ready) begin
                got.data = bus_rd_data;
                got.last = bus_rd_data_last;
                idx      = row.addr[`RAM_ADDR_W+1:2] + `RAM_ADDR_W'(beat);
                check_rd_beat(got, idx, beat, row.len);
                beat++;
            end
        end
        @(negedge BUS_CLK);
        bus_rd_data_ready = 1'b0;
    endtask

    initial begin
        wait (table_ready === 1'b1);
        #(budget_ns);
        fail_run($sformatf("Timeout: the run did not finish within %0d ns", budget_ns));
    end

    initial begin
        BUS_RST           = 1'b1;
        bus_wr_addr       = '0;
        bus_wr_len        = '0;
        bus_wr_addr_valid = 1'b0;
        bus_wr_data       = '0;
        bus_wr_strb       = '0;
        bus_wr_data_last  = 1'b0;
        bus_wr_data_valid = 1'b0;
        bus_rd_addr       = '0;
        bus_rd_len        = '0;
        bus_rd_addr_valid = 1'b0;
        bus_rd_data_ready = 1'b0;
        lcg_state         = 32'd67;
        table_ready       = 1'b0;
        load_table();
        budget_ns = 10000;
        foreach (rows[r]) begin
            budget_ns += (rows[r].len + 1) * 400;
        end
        table_ready = 1'b1;

        repeat (3) @(posedge SLAVE_CLK);
        @(negedge BUS_CLK);
        check_flag(bus_wr_addr_ready, 1'b0, "bus_wr_addr_ready in reset");
        check_flag(bus_wr_data_ready, 1'b0, "bus_wr_data_ready in reset");
        check_flag(bus_rd_addr_ready, 1'b0, "bus_rd_addr_ready in reset");
        BUS_RST = 1'b0;

        repeat (4) @(negedge BUS_CLK);
        check_flag(bus_rd_data_valid, 1'b0, "bus_rd_data_valid after reset");
        check_flag(bus_wr_addr_ready, 1'b1, "bus_wr_addr_ready after reset");
        check_flag(bus_wr_data_ready, 1'b1, "bus_wr_data_ready after reset");
        check_flag(bus_rd_addr_ready, 1'b1, "bus_rd_addr_ready after reset");

        for (int r = 0; r < N_ROWS; r++) begin
            if (rows[r].kind == ROW_WRITE) begin
                write_burst(rows[r]);
            end else begin
                read_burst(rows[r]);
            end
        end

        repeat (20) @(negedge BUS_CLK);
        check_flag(bus_rd_data_valid, 1'b0, "bus_rd_data_valid after the last read");
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
axi_bridge_pkg.sv
axi_slave_if.sv
async_fifo.sv
slave_axi_async.sv
slave_ram.sv
axi_ram_subsystem.sv
tb_axi_ram_subsystem.sv
